// File: rtl/eth_gen_macros.svh
// protocol constants for the GMII receive frame generator
// include in any RTL file that needs byte values, frame sizes or CRC parameters

`ifndef ETH_GEN_MACROS_SVH
`define ETH_GEN_MACROS_SVH

// -------------------------------------------------------------------------
// line byte values
// -------------------------------------------------------------------------
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD_BYTE       8'hD5
// sfd with a corrupted high nibble, flags a preamble error at the MAC
`define ETH_SFD_ERR_BYTE   8'hF5

// 802.1Q tag protocol id
`define ETH_VLAN_TPID      16'h8100

// -------------------------------------------------------------------------
// frame size
// -------------------------------------------------------------------------
// dst through last pad byte, fcs not counted
`define ETH_MIN_FRAME      16'd60

// -------------------------------------------------------------------------
// CRC-32 as in IEEE 802.3
// -------------------------------------------------------------------------
`define ETH_CRC_POLY       32'h04C1_1DB7
`define ETH_CRC_INIT       32'hFFFF_FFFF   // all ones start value

`endif

// File: rtl/eth_frame_pkg.sv
// frame level types of the GMII receive frame generator
// the command that describes one frame and the per-byte position record
// that the sequencer hands to both byte sources

package eth_frame_pkg;

   typedef logic [7:0]  octet_t;      // one byte on the line
   typedef logic [47:0] mac_addr_t;
   typedef logic [15:0] word16_t;     // length, type, tag control or gap count

   // frame command, captured once per frame at the start strobe
   typedef struct packed {
      mac_addr_t  dst;
      mac_addr_t  src;
      logic       mac_reverse;   // addresses high byte first
      logic [4:0] prmble_len;    // 0 sends the sfd right away
      logic       vlan_en;
      word16_t    vlan_ctl;
      word16_t    len;           // payload bytes
      word16_t    frmtype;       // non-zero replaces len on the line
      octet_t     cntstart;
      octet_t     cntstep;
      word16_t    ipg_len;       // idle cycles after the fcs
      logic       pad_en;
      logic       prmbl_err;
      logic       payload_err;
      logic       crc_err;
   } frame_cmd_t;

   // field that a byte belongs to
   typedef enum logic [3:0] {
      FLD_IDLE,
      FLD_PREAMBLE,
      FLD_SFD,
      FLD_DST,
      FLD_SRC,
      FLD_TAG,
      FLD_LEN,
      FLD_PAYLOAD,
      FLD_PAD,
      FLD_CRC
   } field_kind_e;

   typedef struct packed {
      field_kind_e kind;
      word16_t     idx;    // byte index within the field
      logic        last;   // last byte of the field
      logic        sof;    // first byte of the frame on the line
      logic        eof;    // last fcs byte
   } field_pos_t;

endpackage

// File: rtl/gmii_pkg.sv
// GMII side types of the frame generator
// the header byte lane between the header source and the transmit stage
// and the CRC register

package gmii_pkg;

   import eth_frame_pkg::*;

   typedef logic [31:0] crc_t;

   // one registered header byte with its field kind and frame flags
   typedef struct packed {
      octet_t      data;
      field_kind_e kind;   // steers the byte select downstream
      logic        sof;
      logic        eof;
   } lane_byte_t;

endpackage

// File: rtl/frame_sequencer.sv
// frame sequencer of the GMII receive frame generator
// takes a command on start_i while done_o is high, then emits one field
// position per cycle from the next edge on, followed by the inter-packet gap
// done_o returns high once the gap has been seen at the GMII outputs

`timescale 1ns/1ns
`include "eth_gen_macros.svh"

module frame_sequencer
   import eth_frame_pkg::*;
(
   input  logic       rx_clk_gen,
   input  logic       reset,
   input  logic       start_i,
   input  frame_cmd_t cmd_i,
   output frame_cmd_t cmd_o,
   output field_pos_t pos_o,
   output logic       done_o
);

   typedef enum logic [3:0] {
      S_IDLE, S_PRE, S_SFD, S_DST, S_SRC, S_TAG, S_LEN, S_PAY, S_PAD, S_CRC, S_IPG
   } seq_state_e;

   seq_state_e  state;
   seq_state_e  next_field;
   word16_t     idx;
   word16_t     frame_cnt;    // 0 at first dst byte
   logic [16:0] gap_cnt;
   logic        field_last;
   logic        pad_needed;
   logic        frame_first;
   logic        frame_last;
   logic        start_ok;
   field_kind_e kind;

   assign start_ok    = start_i & done_o;
   assign pad_needed  = cmd_o.pad_en & (frame_cnt < `ETH_MIN_FRAME - 16'd1);
   assign frame_first = ((state == S_PRE) && (idx == 16'd0)) ||
                        ((state == S_SFD) && (cmd_o.prmble_len == 5'd0));
   assign frame_last  = (state == S_CRC) & field_last;

   // -------------------------------------------------------------------------
   // field decode
   // -------------------------------------------------------------------------
   always_comb
   begin
      case (state)
         S_PRE:        field_last = (idx == {11'd0, cmd_o.prmble_len} - 16'd1);
         S_SFD:        field_last = 1'b1;
         S_DST, S_SRC: field_last = (idx == 16'd5);
         S_TAG, S_CRC: field_last = (idx == 16'd3);
         S_LEN:        field_last = (idx == 16'd1);
         S_PAY:        field_last = (idx == cmd_o.len - 16'd1);
         S_PAD:        field_last = (frame_cnt == `ETH_MIN_FRAME - 16'd1);
         default:      field_last = 1'b0;
      endcase
   end

   always_comb
   begin
      case (state)
         S_PRE:   next_field = S_SFD;
         S_SFD:   next_field = S_DST;
         S_DST:   next_field = S_SRC;
         S_SRC:   next_field = cmd_o.vlan_en ? S_TAG : S_LEN;
         S_TAG:   next_field = S_LEN;
         S_LEN:
         begin
            if (cmd_o.len != 16'd0)
               next_field = S_PAY;
            else
               next_field = pad_needed ? S_PAD : S_CRC;   // zero length frame
         end
         S_PAY:   next_field = pad_needed ? S_PAD : S_CRC;
         S_PAD:   next_field = S_CRC;
         S_CRC:   next_field = S_IPG;
         default: next_field = S_IDLE;
      endcase
   end

   always_comb
   begin
      case (state)
         S_PRE:   kind = FLD_PREAMBLE;
         S_SFD:   kind = FLD_SFD;
         S_DST:   kind = FLD_DST;
         S_SRC:   kind = FLD_SRC;
         S_TAG:   kind = FLD_TAG;
         S_LEN:   kind = FLD_LEN;
         S_PAY:   kind = FLD_PAYLOAD;
         S_PAD:   kind = FLD_PAD;
         S_CRC:   kind = FLD_CRC;
         default: kind = FLD_IDLE;   // idle and gap
      endcase
   end

   // -------------------------------------------------------------------------
   // state machine
   // -------------------------------------------------------------------------
   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         state     <= S_IDLE;
         idx       <= '0;
         frame_cnt <= '0;
         gap_cnt   <= '0;
         done_o    <= 1'b1;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (start_ok)
               begin
                  state  <= (cmd_i.prmble_len != 5'd0) ? S_PRE : S_SFD;
                  done_o <= 1'b0;
               end
               idx <= '0;
            end
            S_IPG:
            begin
               if (gap_cnt == 17'd0)
               begin
                  state  <= S_IDLE;
                  done_o <= 1'b1;
               end
               else
                  gap_cnt <= gap_cnt - 17'd1;
            end
            default:
            begin
               if (field_last)
               begin
                  state <= next_field;
                  idx   <= '0;
               end
               else
                  idx <= idx + 16'd1;
               if (state == S_SFD)
                  frame_cnt <= '0;
               else if (frame_cnt != 16'hFFFF)
                  frame_cnt <= frame_cnt + 16'd1;
               // two extra cycles cover the source and tx stage latency
               gap_cnt <= {1'b0, cmd_o.ipg_len} + 17'd2;
            end
         endcase
      end
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
         cmd_o <= '0;
      else if (start_ok)
         cmd_o <= cmd_i;   // held for the whole frame
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
         pos_o <= '{kind: FLD_IDLE, idx: '0, last: 1'b0, sof: 1'b0, eof: 1'b0};
      else
      begin
         pos_o.kind <= kind;
         pos_o.idx  <= idx;
         pos_o.last <= field_last;
         pos_o.sof  <= frame_first;
         pos_o.eof  <= frame_last;
      end
   end

endmodule

// File: rtl/header_field_source.sv
// header byte source of the GMII receive frame generator
// turns each field position into its header byte: preamble, sfd, addresses,
// VLAN tag, length or type, and pad; payload and fcs positions carry zero
// the byte is registered together with its kind and frame flags

`timescale 1ns/1ns
`include "eth_gen_macros.svh"

module header_field_source
   import eth_frame_pkg::*;
   import gmii_pkg::*;
(
   input  logic       rx_clk_gen,
   input  logic       reset,
   input  frame_cmd_t cmd_i,
   input  field_pos_t pos_i,
   output lane_byte_t hdr_lane_o
);

   octet_t      hdr_byte;
   logic [5:0]  addr_lsb;    // bit offset of the address byte
   logic [4:0]  tag_lsb;
   logic [31:0] tag_word;
   word16_t     type_len;

   assign addr_lsb = cmd_i.mac_reverse ? 6'd40 - {pos_i.idx[2:0], 3'b000}
                                       : {pos_i.idx[2:0], 3'b000};
   assign tag_word = {`ETH_VLAN_TPID, cmd_i.vlan_ctl};
   assign tag_lsb  = 5'd24 - {pos_i.idx[1:0], 3'b000};   // tpid high byte first
   assign type_len = (cmd_i.frmtype != 16'd0) ? cmd_i.frmtype : cmd_i.len;

   always_comb
   begin
      case (pos_i.kind)
         FLD_PREAMBLE: hdr_byte = `ETH_PREAMBLE_BYTE;
         FLD_SFD:      hdr_byte = cmd_i.prmbl_err ? `ETH_SFD_ERR_BYTE : `ETH_SFD_BYTE;
         FLD_DST:      hdr_byte = cmd_i.dst[addr_lsb +: 8];
         FLD_SRC:      hdr_byte = cmd_i.src[addr_lsb +: 8];
         FLD_TAG:      hdr_byte = tag_word[tag_lsb +: 8];
         FLD_LEN:      hdr_byte = pos_i.idx[0] ? type_len[7:0] : type_len[15:8];
         default:      hdr_byte = 8'h00;   // pad, idle, payload and crc slots
      endcase
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
         hdr_lane_o <= '{data: 8'h00, kind: FLD_IDLE, sof: 1'b0, eof: 1'b0};
      else
      begin
         hdr_lane_o.data <= hdr_byte;
         hdr_lane_o.kind <= pos_i.kind;
         hdr_lane_o.sof  <= pos_i.sof;
         hdr_lane_o.eof  <= pos_i.eof;
      end
   end

endmodule

// File: rtl/payload_pattern_gen.sv
// payload byte source of the GMII receive frame generator
// byte 0 is cntstart, byte 1 is cntstep, then a counter that starts at
// cntstart and advances by cntstep; a payload error repeats the byte before
// the last one; runs in step with the header source

`timescale 1ns/1ns

module payload_pattern_gen
   import eth_frame_pkg::*;
(
   input  logic       rx_clk_gen,
   input  logic       reset,
   input  frame_cmd_t cmd_i,
   input  field_pos_t pos_i,
   output octet_t     pay_byte_o
);

   octet_t run_cnt;   // next pattern byte from index 2 on

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         pay_byte_o <= 8'h00;
         run_cnt    <= 8'h00;
      end
      else if (pos_i.kind == FLD_PAYLOAD)
      begin
         if (pos_i.last && cmd_i.payload_err)
            pay_byte_o <= pay_byte_o;   // repeat previous, breaks pattern
         else if (pos_i.idx == 16'd0)
            pay_byte_o <= cmd_i.cntstart;
         else if (pos_i.idx == 16'd1)
            pay_byte_o <= cmd_i.cntstep;
         else
            pay_byte_o <= run_cnt;

         if (pos_i.idx == 16'd0)
            run_cnt <= cmd_i.cntstart;
         else if (pos_i.idx != 16'd1)
            run_cnt <= run_cnt + cmd_i.cntstep;   // wraps mod 256
      end
      else
         pay_byte_o <= 8'h00;
   end

endmodule

// File: rtl/gmii_tx_stage.sv
// transmit stage of the GMII receive frame generator
// selects the header or payload byte, runs the CRC-32 over dst through pad
// and replaces the four fcs slots with the complemented, reflected CRC
// all GMII outputs leave from registers

`timescale 1ns/1ns
`include "eth_gen_macros.svh"

module gmii_tx_stage
   import eth_frame_pkg::*;
   import gmii_pkg::*;
(
   input  logic       rx_clk_gen,
   input  logic       reset,
   input  logic       crc_err_i,
   input  lane_byte_t hdr_lane_i,
   input  octet_t     pay_byte_i,
   output octet_t     rxd_o,
   output logic       rx_dv_o,
   output logic       sop_o,
   output logic       eop_o
);

   crc_t       crc;
   logic [1:0] crc_cnt;     // fcs byte number
   octet_t     crc_byte;
   octet_t     tx_byte;
   logic       crc_cover;

   // bit serial update, data lsb first
   function automatic crc_t crc_step(input crc_t crc_in, input octet_t data);
      crc_t c;
      c = crc_in;
      for (int i = 0; i < 8; i++)
      begin
         if (data[i] ^ c[31])
            c = (c << 1) ^ `ETH_CRC_POLY;
         else
            c = c << 1;
      end
      return c;
   endfunction

   assign crc_cover = hdr_lane_i.kind inside
                      {FLD_DST, FLD_SRC, FLD_TAG, FLD_LEN, FLD_PAYLOAD, FLD_PAD};

   always_comb
   begin
      for (int i = 0; i < 8; i++)
         crc_byte[i] = ~crc[31 - i];   // crc msb goes out first on bit 0
      case (hdr_lane_i.kind)
         FLD_PAYLOAD: tx_byte = pay_byte_i;
         FLD_CRC:     tx_byte = (crc_err_i && crc_cnt == 2'd2) ? ~crc_byte : crc_byte;
         default:     tx_byte = hdr_lane_i.data;
      endcase
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         crc     <= `ETH_CRC_INIT;
         crc_cnt <= 2'd0;
      end
      else
      begin
         if (hdr_lane_i.kind == FLD_SFD)
            crc <= `ETH_CRC_INIT;   // fresh start for the first dst byte
         else if (crc_cover)
            crc <= crc_step(crc, tx_byte);
         else if (hdr_lane_i.kind == FLD_CRC)
            crc <= crc << 8;   // next fcs byte to the top
         crc_cnt <= (hdr_lane_i.kind == FLD_CRC) ? crc_cnt + 2'd1 : 2'd0;
      end
   end

   // -------------------------------------------------------------------------
   // GMII output registers
   // -------------------------------------------------------------------------
   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         rxd_o   <= 8'h00;
         rx_dv_o <= 1'b0;
         sop_o   <= 1'b0;
         eop_o   <= 1'b0;
      end
      else
      begin
         rxd_o   <= tx_byte;
         rx_dv_o <= (hdr_lane_i.kind != FLD_IDLE);
         sop_o   <= hdr_lane_i.sof;
         eop_o   <= hdr_lane_i.eof;
      end
   end

endmodule

// File: rtl/gmii_frame_gen.sv
// GMII receive frame generator, top level
// drives a MAC receive port one byte per rx_clk_gen cycle; pulse start_i
// while done_o is high to send the frame described by cmd_i
// rx_dv_o and sop_o rise three cycles after the accepted start

`timescale 1ns/1ns

module gmii_frame_gen
   import eth_frame_pkg::*;
   import gmii_pkg::*;
(
   input  logic       rx_clk_gen,
   input  logic       reset,
   input  logic       start_i,
   input  frame_cmd_t cmd_i,
   output octet_t     rxd_o,
   output logic       rx_dv_o,
   output logic       sop_o,
   output logic       eop_o,
   output logic       done_o
);

   frame_cmd_t frame_cmd;   // held command of the running frame
   field_pos_t pos;
   lane_byte_t hdr_lane;
   octet_t     pay_byte;

   frame_sequencer i_frame_sequencer (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .start_i    (start_i),
      .cmd_i      (cmd_i),
      .cmd_o      (frame_cmd),
      .pos_o      (pos),
      .done_o     (done_o)
   );

   // both sources see the same position in the same cycle
   header_field_source i_header_field_source (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .cmd_i      (frame_cmd),
      .pos_i      (pos),
      .hdr_lane_o (hdr_lane)
   );

   payload_pattern_gen i_payload_pattern_gen (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .cmd_i      (frame_cmd),
      .pos_i      (pos),
      .pay_byte_o (pay_byte)
   );

   gmii_tx_stage i_gmii_tx_stage (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .crc_err_i  (frame_cmd.crc_err),
      .hdr_lane_i (hdr_lane),
      .pay_byte_i (pay_byte),
      .rxd_o      (rxd_o),
      .rx_dv_o    (rx_dv_o),
      .sop_o      (sop_o),
      .eop_o      (eop_o)
   );

endmodule

// File: testbench/tb_gmii_frame_gen.sv
// testbench for the GMII receive frame generator
// applies a table of frame commands, rebuilds each expected frame with a
// software model and compares it byte by byte at the GMII outputs
// also checks start latency, sop and eop, done_o and the inter-packet gap

`timescale 1ns/1ns

module tb_gmii_frame_gen
   import eth_frame_pkg::*;
();

   localparam int NUM_ROWS  = 6;
   localparam int MAX_BYTES = 2048;

   // one table row holds the command and the expected byte count on the line
   typedef struct packed {
      frame_cmd_t cmd;
      word16_t    frame_len;
   } test_row_t;

   logic       rx_clk_gen;
   logic       reset;
   logic       start_i;
   frame_cmd_t cmd_i;
   octet_t     rxd_o;
   logic       rx_dv_o;
   logic       sop_o;
   logic       eop_o;
   logic       done_o;

   test_row_t   table_rows [0:NUM_ROWS-1];
   octet_t      exp_bytes  [0:MAX_BYTES-1];   // model output of the current row
   int          exp_len;
   int          err_cnt    = 0;
   int          byte_cnt   = 0;
   int          frames_done = 0;
   int          watchdog_cycles;
   bit          limit_ready = 1'b0;
   logic [31:0] rng = 32'd13;

   gmii_frame_gen i_gmii_frame_gen (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .start_i    (start_i),
      .cmd_i      (cmd_i),
      .rxd_o      (rxd_o),
      .rx_dv_o    (rx_dv_o),
      .sop_o      (sop_o),
      .eop_o      (eop_o),
      .done_o     (done_o)
   );

   initial
   begin
      rx_clk_gen = 1'b0;
      forever #5 rx_clk_gen = ~rx_clk_gen;
   end

   // -------------------------------------------------------------------------
   // helpers
   // -------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // reflected CRC-32 update by one byte
   function automatic logic [31:0] crc32_update(input logic [31:0] crc, input octet_t b);
      logic [31:0] c;
      c = crc ^ {24'd0, b};
      for (int i = 0; i < 8; i++)
         c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      return c;
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      err_cnt++;
      $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_val, act_val);
   endtask

   task automatic report_problem(input string msg);
      err_cnt++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic push_byte(input octet_t b);
      exp_bytes[exp_len] = b;
      exp_len++;
   endtask

   // expected line bytes of one frame from the preamble through the fcs
   task automatic build_expected_frame(input frame_cmd_t c);
      int          dst_start;
      logic [31:0] crc;
      word16_t     type_len;
      octet_t      b;
      exp_len = 0;
      for (int k = 0; k < int'(c.prmble_len); k++)
         push_byte(8'h55);
      push_byte(c.prmbl_err ? 8'hF5 : 8'hD5);
      dst_start = exp_len;
      for (int k = 0; k < 6; k++)
         push_byte(c.mac_reverse ? c.dst[47 - 8 * k -: 8] : c.dst[8 * k +: 8]);
      for (int k = 0; k < 6; k++)
         push_byte(c.mac_reverse ? c.src[47 - 8 * k -: 8] : c.src[8 * k +: 8]);
      if (c.vlan_en)
      begin
         push_byte(8'h81);
         push_byte(8'h00);
         push_byte(c.vlan_ctl[15:8]);
         push_byte(c.vlan_ctl[7:0]);
      end
      type_len = (c.frmtype != 16'd0) ? c.frmtype : c.len;
      push_byte(type_len[15:8]);
      push_byte(type_len[7:0]);
      for (int k = 0; k < int'(c.len); k++)
      begin
         if (k == 0)
            b = c.cntstart;
         else if (k == 1)
            b = c.cntstep;
         else
            b = c.cntstart + 8'(k - 2) * c.cntstep;   // mod 256
         if (c.payload_err && k == int'(c.len) - 1 && k > 0)
            b = exp_bytes[exp_len - 1];
         push_byte(b);
      end
      while (c.pad_en && (exp_len - dst_start) < 60)
         push_byte(8'h00);
      crc = 32'hFFFF_FFFF;
      for (int k = dst_start; k < exp_len; k++)
         crc = crc32_update(crc, exp_bytes[k]);
      crc = ~crc;
      push_byte(crc[7:0]);   // fcs low byte first
      push_byte(crc[15:8]);
      push_byte(crc[23:16] ^ {8{c.crc_err}});
      push_byte(crc[31:24]);
   endtask

   task automatic set_row(input int i, input logic [4:0] pre, input logic rev, input logic vlan,
                          input word16_t len, input word16_t ftype, input logic pad,
                          input word16_t ipg, input logic [2:0] errs, input word16_t flen);
      frame_cmd_t c;
      c             = '0;
      c.prmble_len  = pre;
      c.mac_reverse = rev;
      c.vlan_en     = vlan;
      c.vlan_ctl    = vlan ? 16'hA123 : 16'h0000;
      c.len         = len;
      c.frmtype     = ftype;
      c.cntstep     = 8'(2 * i + 1);
      c.ipg_len     = ipg;
      c.pad_en      = pad;
      {c.prmbl_err, c.payload_err, c.crc_err} = errs;
      table_rows[i] = {c, flen};
   endtask

   // table columns are row, preamble, mac_reverse, vlan, len, frmtype, pad_en,
   // ipg, errors {prmbl, payload, crc} and bytes on the line
   task automatic load_table();
      set_row(0, 5'd8, 1'b0, 1'b0, 16'd50, 16'h0000, 1'b0, 16'd12, 3'b000, 16'd77);
      set_row(1, 5'd7, 1'b1, 1'b0, 16'd64, 16'h0800, 1'b0, 16'd5,  3'b000, 16'd90);
      set_row(2, 5'd7, 1'b0, 1'b1, 16'd10, 16'h0000, 1'b1, 16'd8,  3'b000, 16'd72);
      set_row(3, 5'd7, 1'b0, 1'b0, 16'd0,  16'h0000, 1'b1, 16'd0,  3'b000, 16'd72);
      set_row(4, 5'd8, 1'b0, 1'b0, 16'd20, 16'h0000, 1'b0, 16'd3,  3'b110, 16'd47);
      set_row(5, 5'd0, 1'b0, 1'b0, 16'd30, 16'h0000, 1'b1, 16'd20, 3'b001, 16'd65);
   endtask

   // -------------------------------------------------------------------------
   // stimulus and checks
   // -------------------------------------------------------------------------
   initial
   begin
      frame_cmd_t c;
      int         n;
      int         gap;
      reset   = 1'b1;
      start_i = 1'b0;
      cmd_i   = '0;
      load_table();
      watchdog_cycles = 10;   // reset margin
      for (int r = 0; r < NUM_ROWS; r++)
         watchdog_cycles += 2 * (int'(table_rows[r].frame_len) +
                                 int'(table_rows[r].cmd.ipg_len) + 10);
      limit_ready = 1'b1;

      repeat (3) @(posedge rx_clk_gen);
      reset <= 1'b0;
      @(negedge rx_clk_gen);
      if (done_o !== 1'b1)
         report_mismatch("done_o", 1, done_o);
      if (rx_dv_o !== 1'b0)
         report_mismatch("rx_dv_o", 0, rx_dv_o);
      if (sop_o !== 1'b0)
         report_mismatch("sop_o", 0, sop_o);
      if (eop_o !== 1'b0)
         report_mismatch("eop_o", 0, eop_o);

      for (int r = 0; r < NUM_ROWS; r++)
      begin
         c = table_rows[r].cmd;
         rng = xorshift32(rng);
         c.dst[47:16] = rng;
         rng = xorshift32(rng);
         c.dst[15:0]  = rng[15:0];
         c.src[47:32] = rng[31:16];
         rng = xorshift32(rng);
         c.src[31:0]  = rng;
         rng = xorshift32(rng);
         c.cntstart   = rng[7:0];
         build_expected_frame(c);
         if (exp_len != int'(table_rows[r].frame_len))
            report_problem($sformatf("row %0d model gives %0d bytes, table says %0d",
                                     r, exp_len, table_rows[r].frame_len));

         while (done_o !== 1'b1)
            @(negedge rx_clk_gen);
         @(posedge rx_clk_gen);
         start_i <= 1'b1;
         cmd_i   <= c;
         @(posedge rx_clk_gen);   // start accepted here
         start_i <= 1'b0;

         for (int k = 0; k < 3; k++)
         begin
            @(negedge rx_clk_gen);
            if (rx_dv_o !== 1'b0)
               report_mismatch("rx_dv_o", 0, rx_dv_o);
         end
         @(negedge rx_clk_gen);
         if (rx_dv_o !== 1'b1)
            report_problem($sformatf("frame %0d missing 3 cycles after start", r));

         n = 0;
         while (rx_dv_o === 1'b1 && n < MAX_BYTES)
         begin
            if (n < exp_len && rxd_o !== exp_bytes[n])
               report_mismatch($sformatf("rxd_o byte %0d", n), exp_bytes[n], rxd_o);
            if (sop_o !== (n == 0))
               report_mismatch($sformatf("sop_o byte %0d", n), (n == 0), sop_o);
            if (eop_o !== (n == exp_len - 1))
               report_mismatch($sformatf("eop_o byte %0d", n), (n == exp_len - 1), eop_o);
            if (done_o !== 1'b0)
               report_mismatch("done_o", 0, done_o);
            n++;
            @(negedge rx_clk_gen);
         end
         byte_cnt += n;
         if (n != exp_len)
            report_problem($sformatf("frame %0d has %0d bytes, expected %0d", r, n, exp_len));

         // gap until done_o returns
         gap = 0;
         while (done_o !== 1'b1)
         begin
            if (rx_dv_o !== 1'b0 || sop_o !== 1'b0 || eop_o !== 1'b0)
               report_problem("stray rx_dv_o, sop_o or eop_o in the gap");
            gap++;
            @(negedge rx_clk_gen);
         end
         if (gap < int'(c.ipg_len))
            report_problem($sformatf("gap after frame %0d is %0d cycles, expected %0d",
                                     r, gap, c.ipg_len));
         frames_done++;
      end

      $display("frames %0d, bytes checked %0d, errors %0d", frames_done, byte_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // watchdog with a limit from the table
   initial
   begin
      wait (limit_ready);
      repeat (watchdog_cycles) @(posedge rx_clk_gen);
      $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
      $display("frames %0d, bytes checked %0d, errors %0d", frames_done, byte_cnt, err_cnt);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: src.f
+incdir+rtl
rtl/eth_frame_pkg.sv
rtl/gmii_pkg.sv
rtl/frame_sequencer.sv
rtl/header_field_source.sv
rtl/payload_pattern_gen.sv
rtl/gmii_tx_stage.sv
rtl/gmii_frame_gen.sv
testbench/tb_gmii_frame_gen.sv

// File: Bender.yml
package:
  name: gmii_frame_gen

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/eth_frame_pkg.sv
      - rtl/gmii_pkg.sv
      - rtl/frame_sequencer.sv
      - rtl/header_field_source.sv
      - rtl/payload_pattern_gen.sv
      - rtl/gmii_tx_stage.sv
      - rtl/gmii_frame_gen.sv
  - target: test
    files:
      - testbench/tb_gmii_frame_gen.sv
